//--- design/router_macros.svh
`ifndef ROUTER_MACROS_SVH
`define ROUTER_MACROS_SVH

//////////////////////////////
// flit field widths
//////////////////////////////

// data word carried by every flit
`define FLIT_PAYLOAD_WIDTH 32

// message tag kept from the collective header
`define FLIT_TAG_WIDTH 8

// one mesh coordinate, x or y
`define FLIT_COORD_WIDTH 3

//////////////////////////////
// router sizing
//////////////////////////////

// entries in each input and switch queue
`define ROUTER_QUEUE_DEPTH 4

// network ports per node, xpos and ypos
`define ROUTER_NUM_PORTS 2

`endif

//--- design/router_pkg.sv
`include "router_macros.svh"

package router_pkg;

    //////////////////////////////
    // link flit
    //////////////////////////////

    // valid sits in the msb, as on the original links
    // destination first, then source, tag and data
    typedef struct packed {
        logic                            valid;
        logic [`FLIT_COORD_WIDTH-1:0]    dst_x;
        logic [`FLIT_COORD_WIDTH-1:0]    dst_y;
        logic [`FLIT_COORD_WIDTH-1:0]    src_x;
        logic [`FLIT_COORD_WIDTH-1:0]    src_y;
        logic [`FLIT_TAG_WIDTH-1:0]      tag;
        logic [`FLIT_PAYLOAD_WIDTH-1:0]  payload;
    } flit_t;

    //////////////////////////////
    // routing decision
    //////////////////////////////

    // output link picked by dimension order
    typedef enum logic [0:0] {
        DIR_XPOS = 1'b0,
        DIR_YPOS = 1'b1
    } out_dir_t;

    // flit tagged with its output, as held in a switch queue
    typedef struct packed {
        out_dir_t dir;
        flit_t    flit;
    } routed_flit_t;

endpackage

//--- design/flit_fifo.sv
`timescale 1ns/10ps
`include "router_macros.svh"

module flit_fifo #(
    parameter type item_t = logic,
    parameter int  depth  = `ROUTER_QUEUE_DEPTH
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  push,
    input  logic  pop,
    input  item_t din,
    output item_t dout,
    output logic  empty,
    output logic  full
);

    // pointer and occupancy widths
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    // storage ring
    item_t mem [depth];

    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] wr_ptr;
    logic [cnt_w-1:0] count;

    // advance with wrap at depth
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // write port
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    // pointers and count
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // simultaneous push and pop keeps the count
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // show-ahead head
    assign dout  = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == cnt_w'(depth));

endmodule

//--- design/route_comp.sv
`timescale 1ns/10ps
`include "router_macros.svh"

module route_comp #(
    parameter int cur_x = 0,
    parameter int cur_y = 0
) (
    input  logic                       clk,
    input  logic                       rst,
    input  router_pkg::flit_t          head,
    input  logic                       head_empty,
    input  logic                       stall,
    output logic                       pop,
    output router_pkg::routed_flit_t   routed,
    output logic                       routed_push,
    output router_pkg::flit_t          eject
);

    // node coordinates at field width
    localparam logic [`FLIT_COORD_WIDTH-1:0] node_x = `FLIT_COORD_WIDTH'(cur_x);
    localparam logic [`FLIT_COORD_WIDTH-1:0] node_y = `FLIT_COORD_WIDTH'(cur_y);

    logic                     is_local;
    router_pkg::out_dir_t     dir;
    router_pkg::routed_flit_t routed_q;
    logic                     routed_valid;
    router_pkg::flit_t        eject_q;
    logic                     eject_valid;

    //////////////////////////////
    // dimension order decision
    //////////////////////////////

    // x first, then y, else this node
    assign is_local = (head.dst_x == node_x) && (head.dst_y == node_y);
    assign dir      = (head.dst_x != node_x) ? router_pkg::DIR_XPOS : router_pkg::DIR_YPOS;

    // take a flit only while the switch queue has room
    assign pop = !head_empty && !stall;

    // registered flit and its routing decision
    always_ff @(posedge clk) begin
        if (pop) begin
            routed_q.dir  <= dir;
            routed_q.flit <= head;
            eject_q       <= head;
        end
    end

    // routed entry holds while the switch queue is full
    always_ff @(posedge clk) begin
        if (rst) begin
            routed_valid <= 1'b0;
            eject_valid  <= 1'b0;
        end else begin
            if (!stall) begin
                routed_valid <= pop && !is_local;
            end
            eject_valid <= pop && is_local;
        end
    end

    assign routed      = routed_q;
    assign routed_push = routed_valid && !stall;

    // eject pulse lasts one cycle
    always_comb begin
        eject       = eject_q;
        eject.valid = eject_valid;
    end

endmodule

//--- design/rr_arbiter.sv
`timescale 1ns/10ps
`include "router_macros.svh"

module rr_arbiter (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [`ROUTER_NUM_PORTS-1:0]  req,
    input  logic                          block,
    output logic [`ROUTER_NUM_PORTS-1:0]  grant
);

    // low means requester 0 (xpos queue) goes first
    logic prio;

    // fixed order from the pointer, nothing while blocked
    always_comb begin
        grant = '0;
        if (!block) begin
            if (!prio) begin
                if (req[0]) grant = 2'b01;
                else if (req[1]) grant = 2'b10;
            end else begin
                if (req[1]) grant = 2'b10;
                else if (req[0]) grant = 2'b01;
            end
        end
    end

    // winner drops to lowest priority
    always_ff @(posedge clk) begin
        if (rst) begin
            prio <= 1'b0;
        end else if (grant[0]) begin
            prio <= 1'b1;
        end else if (grant[1]) begin
            prio <= 1'b0;
        end
    end

endmodule

//--- design/switch_alloc.sv
`timescale 1ns/10ps
`include "router_macros.svh"

module switch_alloc (
    input  logic                       clk,
    input  logic                       rst,
    input  router_pkg::routed_flit_t   head_xpos,
    input  router_pkg::routed_flit_t   head_ypos,
    input  logic                       empty_xpos,
    input  logic                       empty_ypos,
    input  router_pkg::flit_t          inject_xpos,
    input  router_pkg::flit_t          inject_ypos,
    output logic                       pop_xpos,
    output logic                       pop_ypos,
    output router_pkg::flit_t          out_xpos,
    output router_pkg::flit_t          out_ypos
);

    // bit 0 is the xpos switch queue, bit 1 the ypos one
    logic [`ROUTER_NUM_PORTS-1:0] req_x;
    logic [`ROUTER_NUM_PORTS-1:0] req_y;
    logic [`ROUTER_NUM_PORTS-1:0] grant_x;
    logic [`ROUTER_NUM_PORTS-1:0] grant_y;

    router_pkg::flit_t sel_x;
    router_pkg::flit_t sel_y;
    router_pkg::flit_t out_x_q;
    router_pkg::flit_t out_y_q;
    logic              out_x_valid;
    logic              out_y_valid;

    //////////////////////////////
    // requests and arbitration
    //////////////////////////////

    // each head asks only for the output in its dir
    assign req_x[0] = !empty_xpos && (head_xpos.dir == router_pkg::DIR_XPOS);
    assign req_x[1] = !empty_ypos && (head_ypos.dir == router_pkg::DIR_XPOS);
    assign req_y[0] = !empty_xpos && (head_xpos.dir == router_pkg::DIR_YPOS);
    assign req_y[1] = !empty_ypos && (head_ypos.dir == router_pkg::DIR_YPOS);

    // local inject claims the output
    rr_arbiter arb_xpos (
        .clk   (clk),
        .rst   (rst),
        .req   (req_x),
        .block (inject_xpos.valid),
        .grant (grant_x)
    );

    rr_arbiter arb_ypos (
        .clk   (clk),
        .rst   (rst),
        .req   (req_y),
        .block (inject_ypos.valid),
        .grant (grant_y)
    );

    // a head wins at most one output
    assign pop_xpos = grant_x[0] | grant_y[0];
    assign pop_ypos = grant_x[1] | grant_y[1];

    //////////////////////////////
    // switch traversal
    //////////////////////////////

    // inject first, then the granted head, else idle
    function automatic router_pkg::flit_t pick(
        input router_pkg::flit_t                inj,
        input logic [`ROUTER_NUM_PORTS-1:0]     grant,
        input router_pkg::routed_flit_t         hx,
        input router_pkg::routed_flit_t         hy
    );
        router_pkg::flit_t f;
        f = '0;
        if (inj.valid) f = inj;
        else if (grant[0]) f = hx.flit;
        else if (grant[1]) f = hy.flit;
        return f;
    endfunction

    assign sel_x = pick(inject_xpos, grant_x, head_xpos, head_ypos);
    assign sel_y = pick(inject_ypos, grant_y, head_xpos, head_ypos);

    always_ff @(posedge clk) begin
        out_x_q <= sel_x;
        out_y_q <= sel_y;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_x_valid <= 1'b0;
            out_y_valid <= 1'b0;
        end else begin
            out_x_valid <= sel_x.valid;
            out_y_valid <= sel_y.valid;
        end
    end

    // one cycle per flit on each link
    always_comb begin
        out_xpos       = out_x_q;
        out_xpos.valid = out_x_valid;
        out_ypos       = out_y_q;
        out_ypos.valid = out_y_valid;
    end

endmodule

//--- design/router_top.sv
`timescale 1ns/10ps
`include "router_macros.svh"

module router_top #(
    parameter int cur_x = 0,
    parameter int cur_y = 0
) (
    input  logic               clk,
    input  logic               rst,
    input  router_pkg::flit_t  in_xpos,
    input  router_pkg::flit_t  in_ypos,
    input  router_pkg::flit_t  inject_xpos,
    input  router_pkg::flit_t  inject_ypos,
    output router_pkg::flit_t  out_xpos,
    output router_pkg::flit_t  out_ypos,
    output router_pkg::flit_t  eject_xpos,
    output router_pkg::flit_t  eject_ypos
);

    // input queue to route stage
    router_pkg::flit_t q_x_head;
    router_pkg::flit_t q_y_head;
    logic              q_x_empty;
    logic              q_y_empty;
    logic              q_x_pop;
    logic              q_y_pop;

    // route stage to switch queue
    router_pkg::routed_flit_t rc_x_routed;
    router_pkg::routed_flit_t rc_y_routed;
    logic                     rc_x_push;
    logic                     rc_y_push;

    // switch queue to allocator
    router_pkg::routed_flit_t sw_x_head;
    router_pkg::routed_flit_t sw_y_head;
    logic                     sw_x_empty;
    logic                     sw_y_empty;
    logic                     sw_x_full;
    logic                     sw_y_full;
    logic                     sw_x_pop;
    logic                     sw_y_pop;

    //////////////////////////////
    // input queues
    //////////////////////////////

    // links have no ready, so full goes nowhere
    flit_fifo #(.item_t(router_pkg::flit_t), .depth(`ROUTER_QUEUE_DEPTH)) xpos_input_queue (
        .clk(clk), .rst(rst), .push(in_xpos.valid), .pop(q_x_pop), .din(in_xpos),
        .dout(q_x_head), .empty(q_x_empty), .full()
    );

    flit_fifo #(.item_t(router_pkg::flit_t), .depth(`ROUTER_QUEUE_DEPTH)) ypos_input_queue (
        .clk(clk), .rst(rst), .push(in_ypos.valid), .pop(q_y_pop), .din(in_ypos),
        .dout(q_y_head), .empty(q_y_empty), .full()
    );

    //////////////////////////////
    // route computation
    //////////////////////////////

    route_comp #(.cur_x(cur_x), .cur_y(cur_y)) xpos_route_comp (
        .clk(clk), .rst(rst), .head(q_x_head), .head_empty(q_x_empty), .stall(sw_x_full),
        .pop(q_x_pop), .routed(rc_x_routed), .routed_push(rc_x_push), .eject(eject_xpos)
    );

    route_comp #(.cur_x(cur_x), .cur_y(cur_y)) ypos_route_comp (
        .clk(clk), .rst(rst), .head(q_y_head), .head_empty(q_y_empty), .stall(sw_y_full),
        .pop(q_y_pop), .routed(rc_y_routed), .routed_push(rc_y_push), .eject(eject_ypos)
    );

    //////////////////////////////
    // switch queues and switch
    //////////////////////////////

    // one queue per input port, drained by grants
    flit_fifo #(.item_t(router_pkg::routed_flit_t), .depth(`ROUTER_QUEUE_DEPTH)) xpos_switch_queue (
        .clk(clk), .rst(rst), .push(rc_x_push), .pop(sw_x_pop), .din(rc_x_routed),
        .dout(sw_x_head), .empty(sw_x_empty), .full(sw_x_full)
    );

    flit_fifo #(.item_t(router_pkg::routed_flit_t), .depth(`ROUTER_QUEUE_DEPTH)) ypos_switch_queue (
        .clk(clk), .rst(rst), .push(rc_y_push), .pop(sw_y_pop), .din(rc_y_routed),
        .dout(sw_y_head), .empty(sw_y_empty), .full(sw_y_full)
    );

    switch_alloc sw_inst (
        .clk         (clk),
        .rst         (rst),
        .head_xpos   (sw_x_head),
        .head_ypos   (sw_y_head),
        .empty_xpos  (sw_x_empty),
        .empty_ypos  (sw_y_empty),
        .inject_xpos (inject_xpos),
        .inject_ypos (inject_ypos),
        .pop_xpos    (sw_x_pop),
        .pop_ypos    (sw_y_pop),
        .out_xpos    (out_xpos),
        .out_ypos    (out_ypos)
    );

endmodule

//--- testbench/router_assertions.sv
`timescale 1ns/10ps

module router_assertions (
    input logic clk,
    input logic rst,
    input logic push,
    input logic pop,
    input logic empty,
    input logic full
);

    //////////////////////////////
    // queue usage
    //////////////////////////////

    // links carry no ready so the sender must not overrun
    no_push_when_full: assert property (@(posedge clk) disable iff (rst) !(push && full))
        else $error("push into a full queue");

    // consumer pops only a visible head
    no_pop_when_empty: assert property (@(posedge clk) disable iff (rst) !(pop && empty))
        else $error("pop from an empty queue");

endmodule

// bound to every input and switch queue
bind flit_fifo router_assertions queue_checks (
    .clk(clk), .rst(rst), .push(push), .pop(pop), .empty(empty), .full(full)
);

//--- testbench/router_tb.sv
`timescale 1ns/10ps
`include "router_macros.svh"

module router_tb;

    logic clk = 1'b0;
    logic rst;
    router_pkg::flit_t in_xpos, in_ypos, inject_xpos, inject_ypos;
    router_pkg::flit_t out_xpos, out_ypos, eject_xpos, eject_ypos;

    int seed = 2;
    int errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    // output index order used by port_flit
    string port_name [4] = '{"out_xpos", "out_ypos", "eject_xpos", "eject_ypos"};

    // node sits at (2,1)
    router_top #(.cur_x(2), .cur_y(1)) uut (
        .clk(clk), .rst(rst), .in_xpos(in_xpos), .in_ypos(in_ypos),
        .inject_xpos(inject_xpos), .inject_ypos(inject_ypos),
        .out_xpos(out_xpos), .out_ypos(out_ypos),
        .eject_xpos(eject_xpos), .eject_ypos(eject_ypos)
    );

    // 8 ns period
    always #4 clk = ~clk;

    //////////////////////////////
    // compare and helper tasks
    //////////////////////////////

    task automatic compare_flit(input string name, input router_pkg::flit_t act,
                                input router_pkg::flit_t exp);
        if (act !== exp) begin
            $display("FAILED at %0t ns: %s = %h, expected %h", $time, name, act, exp);
            errors++;
        end
    endtask

    task automatic compare_valid(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            $display("FAILED at %0t ns: %s.valid = %b, expected %b", $time, name, act, exp);
            errors++;
        end
    endtask

    task automatic compare_count(input string name, input int act, input int exp);
        if (act != exp) begin
            $display("FAILED at %0t ns: %s = %0d, expected %0d", $time, name, act, exp);
            errors++;
        end
    endtask

    // valid flit with a fixed source of (1,0)
    function automatic router_pkg::flit_t make_flit(input int dx, input int dy, input int tag,
                                                    input logic [31:0] payload);
        router_pkg::flit_t f;
        f.valid   = 1'b1;
        f.dst_x   = `FLIT_COORD_WIDTH'(dx);
        f.dst_y   = `FLIT_COORD_WIDTH'(dy);
        f.src_x   = `FLIT_COORD_WIDTH'(1);
        f.src_y   = `FLIT_COORD_WIDTH'(0);
        f.tag     = `FLIT_TAG_WIDTH'(tag);
        f.payload = payload;
        return f;
    endfunction

    function automatic router_pkg::flit_t port_flit(input int port);
        case (port)
            0:       return out_xpos;
            1:       return out_ypos;
            2:       return eject_xpos;
            default: return eject_ypos;
        endcase
    endfunction

    // selected ports keep valid low for a number of cycles
    task automatic expect_quiet(input logic [3:0] ports, input int cycles);
        router_pkg::flit_t g;
        int c;
        int i;
        for (c = 0; c < cycles; c++) begin
            @(negedge clk);
            for (i = 0; i < 4; i++) begin
                g = port_flit(i);
                if (ports[i]) compare_valid(port_name[i], g.valid, 1'b0);
            end
        end
    endtask

    // wait for one output flit while the idle ports stay quiet
    task automatic await_flit(input int port, input router_pkg::flit_t exp, input string what,
                              input logic [3:0] idle);
        router_pkg::flit_t f;
        router_pkg::flit_t g;
        int cycles;
        int i;
        cycles = 0;
        f = '0;
        while (!f.valid && cycles < 20) begin
            @(negedge clk);
            cycles++;
            f = port_flit(port);
            for (i = 0; i < 4; i++) begin
                g = port_flit(i);
                if (idle[i]) compare_valid(port_name[i], g.valid, 1'b0);
            end
        end
        if (!f.valid) begin
            $display("timeout: %s never arrived on %s", what, port_name[port]);
            errors++;
        end else begin
            compare_flit(port_name[port], f, exp);
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errs_before);
        end
    endtask

    //////////////////////////////
    // directed tests
    //////////////////////////////

    task automatic idle_after_reset();
        int e;
        e = errors;
        expect_quiet(4'b1111, 10);
        end_test("idle_after_reset", e);
    endtask

    task automatic local_eject();
        router_pkg::flit_t f;
        int e;
        e = errors;
        f = make_flit(2, 1, 8'h21, $random(seed));
        in_ypos = f;
        @(negedge clk);
        in_ypos = '0;
        // out_xpos, out_ypos and eject_xpos stay quiet
        await_flit(3, f, "local flit", 4'b0111);
        // a copy sent on to the switch would show up within a few cycles
        expect_quiet(4'b1111, 6);
        // same decision on the xpos input
        f = make_flit(2, 1, 8'h22, $random(seed));
        in_xpos = f;
        @(negedge clk);
        in_xpos = '0;
        await_flit(2, f, "local flit on xpos", 4'b1011);
        expect_quiet(4'b1111, 6);
        end_test("local_eject", e);
    endtask

    task automatic dimension_order();
        router_pkg::flit_t fx;
        router_pkg::flit_t fy;
        int e;
        e = errors;
        // x differs, so xpos
        fx = make_flit(5, 1, 8'h31, $random(seed));
        in_xpos = fx;
        @(negedge clk);
        in_xpos = '0;
        await_flit(0, fx, "x-bound flit", 4'b1110);
        // x matches, y differs
        fy = make_flit(2, 3, 8'h32, $random(seed));
        in_ypos = fy;
        @(negedge clk);
        in_ypos = '0;
        await_flit(1, fy, "y-bound flit", 4'b1101);
        end_test("dimension_order", e);
    endtask

    task automatic inject_override();
        router_pkg::flit_t link;
        router_pkg::flit_t inj;
        int e;
        int i;
        e = errors;
        link = make_flit(6, 1, 8'h41, $random(seed));
        in_xpos = link;
        // four inject cycles cover the cycle the link head first requests
        for (i = 0; i < 4; i++) begin
            inj = make_flit(0, 0, 8'h48 + i, $random(seed));
            inject_xpos = inj;
            @(negedge clk);
            in_xpos = '0;
            compare_flit("out_xpos", out_xpos, inj);
        end
        inject_xpos = '0;
        await_flit(0, link, "link flit behind inject", 4'b1110);
        end_test("inject_override", e);
    endtask

    task automatic merged_burst();
        router_pkg::flit_t sent [8];
        bit hit [8];
        int e;
        int i;
        int k;
        int delivered;
        int unmatched;
        int tail;
        int cycles;
        e = errors;
        delivered = 0;
        unmatched = 0;
        tail = 0;
        cycles = 0;
        for (i = 0; i < 4; i++) begin
            sent[i]     = make_flit(4, i, 8'h50 + i, $random(seed));
            sent[i + 4] = make_flit(0, i, 8'h60 + i, $random(seed));
            hit[i]      = 1'b0;
            hit[i + 4]  = 1'b0;
        end
        for (i = 0; i < 4; i++) begin
            @(negedge clk);
            in_xpos = sent[i];
            in_ypos = sent[i + 4];
        end
        @(negedge clk);
        in_xpos = '0;
        in_ypos = '0;
        // match each arrival once, then watch a few cycles for repeats
        while ((delivered < 8 || tail < 4) && cycles < 40) begin
            if (out_xpos.valid) begin
                k = 0;
                while (k < 8 && (hit[k] || out_xpos !== sent[k])) k++;
                if (k < 8) begin
                    hit[k] = 1'b1;
                    delivered++;
                end else begin
                    unmatched++;
                end
            end
            compare_valid("out_ypos", out_ypos.valid, 1'b0);
            if (delivered == 8) tail++;
            @(negedge clk);
            cycles++;
        end
        if (delivered < 8) begin
            $display("timeout: only %0d of 8 burst flits reached out_xpos", delivered);
            errors++;
        end
        compare_count("burst delivered", delivered, 8);
        compare_count("burst unmatched or repeated", unmatched, 0);
        end_test("merged_burst", e);
    endtask

    initial begin
        rst = 1'b1;
        in_xpos = '0;
        in_ypos = '0;
        inject_xpos = '0;
        inject_ypos = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        idle_after_reset();
        local_eject();
        dimension_order();
        inject_override();
        merged_burst();
        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (errors == 0 && tests_failed == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- router_top.f
+incdir+design
design/router_pkg.sv
design/flit_fifo.sv
design/route_comp.sv
design/rr_arbiter.sv
design/switch_alloc.sv
design/router_top.sv
testbench/router_assertions.sv
testbench/router_tb.sv

//--- Bender.yml
package:
  name: router_top

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/router_pkg.sv
      - design/flit_fifo.sv
      - design/route_comp.sv
      - design/rr_arbiter.sv
      - design/switch_alloc.sv
      - design/router_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/router_assertions.sv
      - testbench/router_tb.sv
